//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_gem_rx_fabric
FILELIST   := gem_rx_fabric.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation printed the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- gem_rx_fabric.f
+incdir+tests
verilog/gem_rx_pkg.sv
verilog/prbs_err_monitor.sv
verilog/rx_status_sync.sv
verilog/link_data_stage.sv
verilog/bx_delay_line.sv
verilog/gem_rx_fabric.sv
tests/tb_gem_rx_fabric.sv

//--- tests/tb_gem_rx_vectors.svh
// Row fields: posneg, delay_is, link_good, link_bad, prbs_test_en, failed words, k_char_raw
// Failed words are the first strobed words of the row sent valid but unmatched
typedef struct packed {
  logic       posneg;     // Extra stage in the data path
  logic [3:0] delay;      // delay_is, 0 gives one bx
  logic       good;       // link_good
  logic       bad;        // link_bad
  logic       prbs;       // prbs_test_en
  logic [3:0] n_fail;     // Mismatched strobed words
  logic [7:0] kcode;      // Sent on strobed words, comma otherwise
} vec_row_t;

localparam int num_rows = 10;

function automatic vec_row_t row_of(input int idx);
  case (idx)
    0:       return '{1'b0, 4'd0,  1'b1, 1'b0, 1'b1, 4'd2, 8'hFC};  // Overflow, short path
    1:       return '{1'b1, 4'd0,  1'b1, 1'b0, 1'b1, 4'd3, 8'h1C};  // BC0 with extra stage
    2:       return '{1'b0, 4'd5,  1'b1, 1'b0, 1'b0, 4'd1, 8'h3C};  // Link count reported
    3:       return '{1'b1, 4'd5,  1'b1, 1'b0, 1'b1, 4'd0, 8'hBC};  // Comma only, no marker
    4:       return '{1'b0, 4'd15, 1'b1, 1'b0, 1'b1, 4'd4, 8'h3C};  // Longest tap
    5:       return '{1'b1, 4'd15, 1'b1, 1'b0, 1'b0, 4'd2, 8'hFC};  // Longest latency
    6:       return '{1'b0, 4'd5,  1'b1, 1'b1, 1'b1, 4'd1, 8'hFC};  // Bad link masked
    7:       return '{1'b1, 4'd3,  1'b0, 1'b0, 1'b1, 4'd2, 8'h1C};  // Link not good
    8:       return '{1'b0, 4'd15, 1'b0, 1'b1, 1'b0, 4'd0, 8'h3C};
    default: return '{1'b0, 4'd0,  1'b1, 1'b0, 1'b1, 4'd5, 8'h1C};  // Back to a clean link
  endcase
endfunction

// ------------------------------------------------------------
// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
// ------------------------------------------------------------
logic [15:0] lfsr_state = 16'd29903;  // Fixed seed

function automatic logic [63:0] take_bits(input int n);
  logic [63:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = {lfsr_state[14:0],
                  lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
    r = {r[62:0], lfsr_state[0]};   // One step per bit taken
  end
  return r;
endfunction

//--- tests/tb_gem_rx_fabric.sv
`default_nettype none

module tb_gem_rx_fabric;

  `include "tb_gem_rx_vectors.svh"

  localparam int row_clocks    = 40;                                   // Clocks per table row
  localparam int watchdog_time = num_rows * row_clocks * 100 + 5000;

  logic        clock;
  logic        gtx_rx_reset;
  logic        frame_strobe;
  logic [55:0] rx_data;
  logic [7:0]  k_char_raw;
  logic        rx_valid;
  logic        rx_match;
  logic        rx_start;
  logic        rx_fc;
  logic        rx_sync_done;
  logic        rx_rst_done;
  logic        clocks_rdy;
  logic        link_good;
  logic        link_bad;
  logic [7:0]  link_errcount;
  logic [15:0] notintable_count;
  logic [15:0] disperr_count;
  logic        clear_sync;
  logic        posneg;
  logic [3:0]  delay_is;
  logic        prbs_test_en;
  logic        gtx_rx_start;
  logic        gtx_rx_fc;
  logic        gtx_rx_valid;
  logic        gtx_rx_match;
  logic        gtx_rx_rst_done;
  logic        gtx_rx_sync_done;
  logic        gtx_rx_err;
  logic [15:0] gtx_rx_err_count;
  logic [15:0] gtx_rx_notintable_count;
  logic [15:0] gtx_rx_disperr_count;
  logic [55:0] gtx_rx_data;
  logic [7:0]  k_char;
  logic        overflow;
  logic        bc0marker;
  logic        resyncmarker;

  int          m_state = 0;             // Expected monitor: 0 wait, 1 clear, 2 count
  logic        m_err = 1'b0;
  logic [15:0] m_count = '0;
  logic [5:0]  exp_flags = '0;          // start, fc, valid, match, sync_done, err after one clock
  logic [15:0] exp_count = '0;
  logic [15:0] exp_nit = '0;
  logic [15:0] exp_disp = '0;
  logic [55:0] hist_d [row_clocks];     // Expected stage output per row clock
  logic [7:0]  hist_k [row_clocks];
  int          errors = 0;
  int          row_errors = 0;
  int          rows_clean = 0;

  gem_rx_fabric UUT (.*);

  always #50 clock = ~clock;            // 100 unit period

  initial begin
    #(watchdog_time);
    $display("Watchdog expired at %0t, the DUT never finished the table", $time);
    $display("Test failures found");
    $finish;
  end

  // ------------------------------------------------------------
  // Checking helpers
  // ------------------------------------------------------------
  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
    row_errors++;
  endtask

  // Expected registers advance on each edge from the inputs held across it
  task automatic update_model();
    if (clear_sync) begin
      exp_flags = '0;                   // Software clear wins
      exp_count = '0;
      exp_nit   = '0;
      exp_disp  = '0;
    end else begin
      exp_flags = {rx_start, rx_fc, rx_valid, rx_match, rx_sync_done, m_err};
      exp_count = prbs_test_en ? m_count : {8'h00, link_errcount};
      exp_nit   = notintable_count;
      exp_disp  = disperr_count;
    end
    if (m_state == 1) begin
      m_err   = 1'b0;                   // One clear clock after link up
      m_count = '0;
    end else if (m_state == 2 && frame_strobe && prbs_test_en) begin
      if (rx_valid && !rx_match) begin
        m_err = 1'b1;
        m_count++;                      // Wraps at 16 bits
      end else if (rx_match) begin
        m_err = 1'b0;
      end
    end
    if (!(rx_sync_done && clocks_rdy)) m_state = 0;
    else if (m_state < 2) m_state++;
  endtask

  task automatic next_edge();
    @(posedge clock);
    update_model();
    #5;                                 // Outputs settled, inputs not yet moved
  endtask

  task automatic check_status();
    logic [5:0] flags;
    flags = {gtx_rx_start, gtx_rx_fc, gtx_rx_valid, gtx_rx_match, gtx_rx_sync_done,
             gtx_rx_err};
    if (flags !== exp_flags)
      report_mismatch("start/fc/valid/match/sync_done/err", 64'(flags), 64'(exp_flags));
    if (gtx_rx_err_count !== exp_count)
      report_mismatch("gtx_rx_err_count", 64'(gtx_rx_err_count), 64'(exp_count));
    if (gtx_rx_notintable_count !== exp_nit)
      report_mismatch("gtx_rx_notintable_count", 64'(gtx_rx_notintable_count), 64'(exp_nit));
    if (gtx_rx_disperr_count !== exp_disp)
      report_mismatch("gtx_rx_disperr_count", 64'(gtx_rx_disperr_count), 64'(exp_disp));
    if (gtx_rx_rst_done !== rx_rst_done)
      report_mismatch("gtx_rx_rst_done", 64'(gtx_rx_rst_done), 64'(rx_rst_done));
  endtask

  task automatic check_data(input int idx);
    logic [7:0] ek;
    logic [2:0] em;
    ek = hist_k[idx];
    em = {ek == 8'hFC, ek == 8'h1C, ek == 8'h3C};   // Overflow, BC0, resync
    if (gtx_rx_data !== hist_d[idx])
      report_mismatch("gtx_rx_data", 64'(gtx_rx_data), 64'(hist_d[idx]));
    if (k_char !== ek)
      report_mismatch("k_char", 64'(k_char), 64'(ek));
    if ({overflow, bc0marker, resyncmarker} !== em)
      report_mismatch("markers", 64'({overflow, bc0marker, resyncmarker}), 64'(em));
  endtask

  // ------------------------------------------------------------
  // One table row, 40 clocks with a strobe every 4th
  // ------------------------------------------------------------
  task automatic run_row(input int r);
    vec_row_t   row;
    int         lat;
    logic       masked;
    logic [7:0] k;
    row        = row_of(r);
    lat        = 2 + int'(row.posneg) + int'(row.delay);
    masked     = !row.good || row.bad;
    row_errors = 0;
    posneg           = row.posneg;
    delay_is         = row.delay;
    link_good        = row.good;
    link_bad         = row.bad;
    prbs_test_en     = row.prbs;
    notintable_count = 16'(take_bits(16));
    disperr_count    = 16'(take_bits(16));
    for (int c = 0; c < row_clocks; c++) begin
      frame_strobe = (c % 4 == 0);
      k            = frame_strobe ? row.kcode : 8'hBC;
      rx_data      = 56'(take_bits(56));
      k_char_raw   = k;
      hist_d[c]    = masked ? '1 : rx_data;
      hist_k[c]    = masked ? 8'h00 : k;
      rx_valid     = frame_strobe | 1'(take_bits(1));
      rx_match     = frame_strobe ? (c / 4 >= int'(row.n_fail)) : 1'(take_bits(1));
      rx_start     = 1'(take_bits(1));                // Status flags only
      rx_fc        = 1'(take_bits(1));
      clear_sync   = (c == 37);
      if (c == 20) link_errcount = 8'(take_bits(8));
      next_edge();
      check_status();
      if (c + 1 >= 20) check_data(c + 1 - lat);     // Controls steady long enough
      #5;
    end
    $display("row %0d posneg %0d delay_is %0d link %0d/%0d prbs %0d k %h: %s", r,
             row.posneg, row.delay, row.good, row.bad, row.prbs, row.kcode,
             row_errors == 0 ? "ok" : "FAILED");
    if (row_errors == 0) rows_clean++;
  endtask

  initial begin
    clock        = 1'b0;
    gtx_rx_reset = 1'b1;
    {frame_strobe, rx_data, k_char_raw, rx_valid, rx_match, rx_start, rx_fc, rx_sync_done,
     rx_rst_done, clocks_rdy, link_good, link_bad, link_errcount, notintable_count,
     disperr_count, clear_sync, posneg, delay_is, prbs_test_en} = '0;
    repeat (8) @(posedge clock);
    #10;
    gtx_rx_reset = 1'b0;
    next_edge();
    check_status();                      // Link still down, all zero
    if ({gtx_rx_start, gtx_rx_fc, overflow, bc0marker, resyncmarker} !== 5'b0)
      report_mismatch("start/fc/markers",
                      64'({gtx_rx_start, gtx_rx_fc, overflow, bc0marker, resyncmarker}), 64'(0));
    $display("reset check: %s", row_errors == 0 ? "ok" : "FAILED");
    if (row_errors == 0) rows_clean++;
    #5;
    rx_sync_done = 1'b1;                 // Bring the link up
    clocks_rdy   = 1'b1;
    rx_rst_done  = 1'b1;
    repeat (4) begin
      next_edge();
      #5;
    end
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("%0d of %0d tests clean, %0d errors", rows_clean, num_rows + 1, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bx_delay_line.sv
`default_nettype none

module bx_delay_line #(
  parameter int unsigned width = 8,   // Vector width
  parameter int unsigned depth = 16   // Number of taps
) (
  input  wire                   clock,
  input  wire                   gtx_rx_reset,
  input  wire gem_rx_pkg::dly_t delay_is,   // Tap select, 0 gives 1 bx
  input  wire [width-1:0]       d,
  output logic [width-1:0]      q
);

  import gem_rx_pkg::*;

  logic [width-1:0] chain [depth];  // Shift register taps
  dly_t             adr_r;          // Registered tap address

  // ------------------------------------------------------------
  // Tap address
  // ------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      adr_r <= '0;
    end else begin
      adr_r <= delay_is;      // Retimed to keep the mux off the input path
    end
  end

  // ------------------------------------------------------------
  // Shift chain
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    chain[0] <= d;                    // Every clock, no enable
    for (int i = 1; i < depth; i++) begin
      chain[i] <= chain[i-1];
    end
  end

  // Tap n holds d from n+1 clocks ago
  assign q = chain[adr_r];

  adr_known_a: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    !$isunknown(adr_r));

endmodule

`default_nettype wire

//--- verilog/gem_rx_fabric.sv
`default_nettype none

module gem_rx_fabric #(
  parameter int unsigned delay_depth = gem_rx_pkg::default_delay_depth
) (
  input  wire                          clock,              // 40 MHz fabric clock
  input  wire                          gtx_rx_reset,
  // Transceiver side
  input  wire                          frame_strobe,       // New word this cycle
  input  wire gem_rx_pkg::gem_data_t   rx_data,
  input  wire gem_rx_pkg::kchar_t      k_char_raw,
  input  wire                          rx_valid,
  input  wire                          rx_match,
  input  wire                          rx_start,
  input  wire                          rx_fc,
  input  wire                          rx_sync_done,
  input  wire                          rx_rst_done,        // Transceiver reset finished
  input  wire                          clocks_rdy,
  input  wire                          link_good,
  input  wire                          link_bad,
  input  wire gem_rx_pkg::link_count_t link_errcount,
  input  wire gem_rx_pkg::count_t      notintable_count,
  input  wire gem_rx_pkg::count_t      disperr_count,
  // Control
  input  wire                          clear_sync,
  input  wire                          posneg,
  input  wire gem_rx_pkg::dly_t        delay_is,
  input  wire                          prbs_test_en,
  // Status
  output logic                         gtx_rx_start,
  output logic                         gtx_rx_fc,
  output logic                         gtx_rx_valid,
  output logic                         gtx_rx_match,
  output logic                         gtx_rx_rst_done,
  output logic                         gtx_rx_sync_done,
  output logic                         gtx_rx_err,
  output gem_rx_pkg::count_t           gtx_rx_err_count,
  output gem_rx_pkg::count_t           gtx_rx_notintable_count,
  output gem_rx_pkg::count_t           gtx_rx_disperr_count,
  // Data
  output gem_rx_pkg::gem_data_t        gtx_rx_data,        // Delayed comparator data
  output gem_rx_pkg::kchar_t           k_char,             // Delayed control character
  output logic                         overflow,
  output logic                         bc0marker,
  output logic                         resyncmarker
);

  import gem_rx_pkg::*;

  logic      err;            // PRBS error flag
  count_t    prbs_errcount;  // PRBS error count
  gem_data_t stage_data;     // Masked and staged data
  kchar_t    stage_kchar;    // Masked and staged control character

  assign gtx_rx_rst_done = rx_rst_done;  // Status only

  // ------------------------------------------------------------
  // Link status and error counts
  // ------------------------------------------------------------
  prbs_err_monitor u_prbs_err_monitor (
    .clock         (clock),
    .gtx_rx_reset  (gtx_rx_reset),
    .frame_strobe  (frame_strobe),
    .rx_valid      (rx_valid),
    .rx_match      (rx_match),
    .rx_sync_done  (rx_sync_done),
    .clocks_rdy    (clocks_rdy),
    .prbs_test_en  (prbs_test_en),
    .err           (err),
    .prbs_errcount (prbs_errcount)
  );

  rx_status_sync u_rx_status_sync (
    .clock                   (clock),
    .gtx_rx_reset            (gtx_rx_reset),
    .clear_sync              (clear_sync),
    .prbs_test_en            (prbs_test_en),
    .rx_start                (rx_start),
    .rx_fc                   (rx_fc),
    .rx_valid                (rx_valid),
    .rx_match                (rx_match),
    .rx_sync_done            (rx_sync_done),
    .err                     (err),
    .prbs_errcount           (prbs_errcount),
    .notintable_count        (notintable_count),
    .disperr_count           (disperr_count),
    .link_errcount           (link_errcount),
    .gtx_rx_start            (gtx_rx_start),
    .gtx_rx_fc               (gtx_rx_fc),
    .gtx_rx_valid            (gtx_rx_valid),
    .gtx_rx_match            (gtx_rx_match),
    .gtx_rx_sync_done        (gtx_rx_sync_done),
    .gtx_rx_err              (gtx_rx_err),
    .gtx_rx_err_count        (gtx_rx_err_count),
    .gtx_rx_notintable_count (gtx_rx_notintable_count),
    .gtx_rx_disperr_count    (gtx_rx_disperr_count)
  );

  // ------------------------------------------------------------
  // Data path
  // ------------------------------------------------------------
  link_data_stage u_link_data_stage (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .link_good    (link_good),
    .link_bad     (link_bad),
    .posneg       (posneg),
    .rx_data      (rx_data),
    .k_char_raw   (k_char_raw),
    .data_out     (stage_data),
    .kchar_out    (stage_kchar)
  );

  // Both delay lines share one tap select so markers stay aligned with data
  bx_delay_line #(.width(gem_data_w), .depth(delay_depth)) u_data_delay (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .delay_is     (delay_is),
    .d            (stage_data),
    .q            (gtx_rx_data)
  );

  bx_delay_line #(.width(kchar_w), .depth(delay_depth)) u_kchar_delay (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .delay_is     (delay_is),
    .d            (stage_kchar),
    .q            (k_char)
  );

  // Marker decode on the delayed control character
  assign overflow     = (k_char == k_overflow);
  assign bc0marker    = (k_char == k_bc0);
  assign resyncmarker = (k_char == k_resync);

endmodule

`default_nettype wire

//--- verilog/gem_rx_pkg.sv
`default_nettype none

package gem_rx_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int unsigned gem_data_w   = 56;  // Comparator data word from the link
  localparam int unsigned kchar_w      = 8;   // Control character from the 8b10b decoder
  localparam int unsigned count_w      = 16;  // Every count reported to software
  localparam int unsigned link_count_w = 8;   // Raw link error count from the transceiver
  localparam int unsigned dly_w        = 4;   // Selects 1 to 16 bx of delay

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------
  typedef logic [gem_data_w-1:0]   gem_data_t;    // One GEM data word
  typedef logic [kchar_w-1:0]      kchar_t;       // One control character
  typedef logic [count_w-1:0]      count_t;       // Reported count
  typedef logic [link_count_w-1:0] link_count_t;  // Raw link error count
  typedef logic [dly_w-1:0]        dly_t;         // Delay line tap address

  // ------------------------------------------------------------
  // Control character codes
  // ------------------------------------------------------------
  localparam kchar_t k_overflow = 8'hFC;  // Sender buffer overflowed
  localparam kchar_t k_bc0      = 8'h1C;  // Bunch crossing zero
  localparam kchar_t k_resync   = 8'h3C;  // Resync seen by the sender

  // ------------------------------------------------------------
  // PRBS error monitor state
  // ------------------------------------------------------------
  // The monitor sits in mon_wait_link until the transceiver has
  // finished its sync and the clocks are locked, clears once, and
  // then counts mismatched test words
  typedef enum logic [1:0] {
    mon_wait_link = 2'd0,  // Link or clocks not ready
    mon_clear     = 2'd1,  // One clock of flag and count clear
    mon_count     = 2'd2   // Checking strobed test words
  } mon_state_t;

  // ------------------------------------------------------------
  // Defaults
  // ------------------------------------------------------------
  localparam int unsigned default_delay_depth = 16;  // Covers every dly_t address

endpackage

`default_nettype wire

//--- verilog/link_data_stage.sv
`default_nettype none

module link_data_stage (
  input  wire                        clock,
  input  wire                        gtx_rx_reset,
  input  wire                        link_good,    // Link monitor says good
  input  wire                        link_bad,     // Link monitor says bad
  input  wire                        posneg,       // Add the extra stage
  input  wire gem_rx_pkg::gem_data_t rx_data,      // Decoded data word
  input  wire gem_rx_pkg::kchar_t    k_char_raw,   // Decoded control character
  output gem_rx_pkg::gem_data_t      data_out,
  output gem_rx_pkg::kchar_t         kchar_out
);

  import gem_rx_pkg::*;

  logic      ignore_link;  // Keep this link out of the trigger data
  logic      posneg_ff;    // Registered stage select
  gem_data_t data_s1;      // First stage
  gem_data_t data_s2;      // Extra stage
  kchar_t    kchar_s1;
  kchar_t    kchar_s2;

  // A bad link would otherwise light every comparator downstream
  assign ignore_link = !link_good || link_bad;

  // ------------------------------------------------------------
  // Stage select
  // ------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      posneg_ff <= 1'b0;
    end else begin
      posneg_ff <= posneg;
    end
  end

  // ------------------------------------------------------------
  // Data stages
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (ignore_link) begin
      data_s1  <= '1;          // All ones marks a masked word
      kchar_s1 <= '0;          // No markers from a masked link
    end else begin
      data_s1  <= rx_data;
      kchar_s1 <= k_char_raw;
    end
    data_s2  <= data_s1;       // Stand-in for the opposite edge
    kchar_s2 <= kchar_s1;
  end

  assign data_out  = posneg_ff ? data_s2 : data_s1;    // One clock later when set
  assign kchar_out = posneg_ff ? kchar_s2 : kchar_s1;

  // Masking must reach the output on the short path
  bad_link_mask_a: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    (link_bad && !posneg) |=> (kchar_out == '0));

endmodule

`default_nettype wire

//--- verilog/prbs_err_monitor.sv
`default_nettype none

module prbs_err_monitor (
  input  wire                clock,
  input  wire                gtx_rx_reset,
  input  wire                frame_strobe,   // New word this cycle
  input  wire                rx_valid,       // Word should match the PRBS pattern
  input  wire                rx_match,       // Word matches the PRBS pattern
  input  wire                rx_sync_done,   // Transceiver sync finished
  input  wire                clocks_rdy,     // QPLL and MMCM locked
  input  wire                prbs_test_en,   // PRBS test mode selected
  output logic               err,            // Last checked word failed
  output gem_rx_pkg::count_t prbs_errcount   // Failed words since the clear
);

  import gem_rx_pkg::*;

  mon_state_t state;      // Current monitor state
  mon_state_t state_nxt;  // Next monitor state
  logic       snap_wait;  // Link not usable yet
  logic       test_word;  // Strobed word to check this cycle

  assign snap_wait = !(rx_sync_done && clocks_rdy);  // Either one dropping sends us back
  assign test_word = (state == mon_count) && frame_strobe && prbs_test_en;

  // ------------------------------------------------------------
  // Monitor FSM
  // ------------------------------------------------------------
  always_comb begin
    state_nxt = state;                    // Hold by default
    if (snap_wait) begin
      state_nxt = mon_wait_link;          // Re-entered from any state
    end else begin
      case (state)
        mon_wait_link: state_nxt = mon_clear;   // Link came up
        mon_clear:     state_nxt = mon_count;   // Single clear cycle
        default:       state_nxt = mon_count;   // Stay counting
      endcase
    end
  end

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      state <= mon_wait_link;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------------------------------------
  // Error flag and counter
  // ------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      err           <= 1'b0;
      prbs_errcount <= '0;
    end else if (state == mon_clear) begin
      err           <= 1'b0;                          // Fresh start after link up
      prbs_errcount <= '0;
    end else if (test_word) begin
      if (rx_valid && !rx_match) begin
        err           <= 1'b1;                        // Scope and LED monitor
        prbs_errcount <= prbs_errcount + count_t'(1); // Wraps at the top
      end else if (rx_match) begin
        err <= 1'b0;                                  // Good word clears the flag
      end
    end
  end

  // Counting only happens in mon_count, the clear state may only zero it
  count_held_a: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    (state != mon_count) |=>
      ((prbs_errcount == $past(prbs_errcount)) || (prbs_errcount == '0)));

endmodule

`default_nettype wire

//--- verilog/rx_status_sync.sv
`default_nettype none

module rx_status_sync (
  input  wire                     clock,
  input  wire                     gtx_rx_reset,
  input  wire                     clear_sync,               // Zero all outputs next edge
  input  wire                     prbs_test_en,             // Report PRBS count instead
  input  wire                     rx_start,                 // Start pattern present
  input  wire                     rx_fc,                    // FC latency code seen
  input  wire                     rx_valid,
  input  wire                     rx_match,
  input  wire                     rx_sync_done,
  input  wire                     err,                      // PRBS error flag
  input  wire gem_rx_pkg::count_t prbs_errcount,
  input  wire gem_rx_pkg::count_t notintable_count,         // 8b10b not-in-table errors
  input  wire gem_rx_pkg::count_t disperr_count,            // 8b10b disparity errors
  input  wire gem_rx_pkg::link_count_t link_errcount,       // Raw link error count
  output logic                    gtx_rx_start,
  output logic                    gtx_rx_fc,
  output logic                    gtx_rx_valid,
  output logic                    gtx_rx_match,
  output logic                    gtx_rx_sync_done,
  output logic                    gtx_rx_err,
  output gem_rx_pkg::count_t      gtx_rx_err_count,         // Link or PRBS errors
  output gem_rx_pkg::count_t      gtx_rx_notintable_count,
  output gem_rx_pkg::count_t      gtx_rx_disperr_count
);

  import gem_rx_pkg::*;

  count_t err_count_sel;  // Count chosen for reporting

  // PRBS count in test mode, otherwise the link count widened
  assign err_count_sel = prbs_test_en ? prbs_errcount
                                      : {{(count_w-link_count_w){1'b0}}, link_errcount};

  // ------------------------------------------------------------
  // Fabric status registers
  // ------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      gtx_rx_start            <= 1'b0;
      gtx_rx_fc               <= 1'b0;
      gtx_rx_valid            <= 1'b0;
      gtx_rx_match            <= 1'b0;
      gtx_rx_sync_done        <= 1'b0;
      gtx_rx_err              <= 1'b0;
      gtx_rx_err_count        <= '0;
      gtx_rx_notintable_count <= '0;
      gtx_rx_disperr_count    <= '0;
    end else if (clear_sync) begin
      gtx_rx_start            <= 1'b0;   // Software clear
      gtx_rx_fc               <= 1'b0;
      gtx_rx_valid            <= 1'b0;
      gtx_rx_match            <= 1'b0;
      gtx_rx_sync_done        <= 1'b0;
      gtx_rx_err              <= 1'b0;
      gtx_rx_err_count        <= '0;
      gtx_rx_notintable_count <= '0;
      gtx_rx_disperr_count    <= '0;
    end else begin
      gtx_rx_start            <= rx_start;
      gtx_rx_fc               <= rx_fc;
      gtx_rx_valid            <= rx_valid;
      gtx_rx_match            <= rx_match;
      gtx_rx_sync_done        <= rx_sync_done;
      gtx_rx_err              <= err;
      gtx_rx_err_count        <= err_count_sel;
      gtx_rx_notintable_count <= notintable_count;
      gtx_rx_disperr_count    <= disperr_count;
    end
  end

endmodule

`default_nettype wire
